// ==== vlog.f ====
+incdir+include
verilog/ppu_oam_pkg.sv
verilog/ppu_line_pkg.sv
verilog/oam_line_scanner.sv
verilog/sprite_x_store.sv
verilog/sprite_match_select.sv
verilog/ppu_sprite_unit.sv
dv/ppu_sprite_unit_tb.sv

// ==== Makefile ====
TOP := ppu_sprite_unit_tb

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== dv/ppu_sprite_unit_tb.sv ====
`timescale 1ns/1ns
`include "ppu_sprite_cfg.svh"

module ppu_sprite_unit_tb import ppu_oam_pkg::*, ppu_line_pkg::*; ();

	localparam int N_CASES = 6;

	// one scan line of stimulus.
	typedef struct packed {
		logic [7:0] line_y;
		logic       tall;
		logic [5:0] n_ent;  // entries fed in oam order.
		logic       edge_y; // walk y across the range edges instead of random.
		logic [7:0] x_mask;
		logic [7:0] x_base;
		logic [4:0] sweep;  // px_x steps from x_base.
		logic       hold;   // stall each hit before taking it.
	} line_case_t;

	logic         clk;
	logic         rst_n;
	logic         line_start;
	logic [7:0]   line_y;
	logic         tall;
	logic         px_active;
	logic         oam_valid;
	logic         oam_ready;
	oam_entry_t   oam;
	logic         px_valid;
	logic         px_ready;
	logic [7:0]   px_x;
	logic         hit_valid;
	logic         hit_ready;
	sprite_hit_t  hit;

	line_case_t   cases [N_CASES];
	oam_entry_t   ents [$];
	sprite_slot_t kept [$];   // expected slot contents in slot order.
	logic [7:0]   stale_x [$];
	integer       seed;
	int           errors;
	int           checks;
	int           cycles = 0;
	int           cycle_limit;

	ppu_sprite_unit i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_start (line_start),
		.line_y     (line_y),
		.tall       (tall),
		.px_active  (px_active),
		.oam_valid  (oam_valid),
		.oam_ready  (oam_ready),
		.oam        (oam),
		.px_valid   (px_valid),
		.px_ready   (px_ready),
		.px_x       (px_x),
		.hit_valid  (hit_valid),
		.hit_ready  (hit_ready),
		.hit        (hit)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic expect_true(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	task automatic expect_hit(input sprite_hit_t exp);
		checks++;
		assert (hit_valid && hit == exp) else begin
			errors++;
			$display("error at %0t: px_x %0d hit_valid %b slot %0d idx %0d, want slot %0d idx %0d",
				$time, px_x, hit_valid, hit.slot, hit.spr.idx, exp.slot, exp.spr.idx);
		end
	endtask

	function automatic int height_of(input logic t);
		return t ? `SPRITE_H_TALL : `SPRITE_H_SHORT;
	endfunction

	task automatic build_entries(input line_case_t lc);
		int         h;
		int         r;
		oam_entry_t e;
		ents.delete();
		h = height_of(lc.tall);
		for (int i = 0; i < int'(lc.n_ent); i++) begin
			if (lc.edge_y)
				r = (i + h) % (h + 4); // far edge first, before the slots fill.
			else
				r = int'($unsigned($random(seed)) % (h + 4));
			e.y    = 8'(int'(lc.line_y) + 16 - (r - 2)); // r - 2 is the row inside the sprite.
			e.x    = lc.x_base + (8'($random(seed)) & lc.x_mask);
			e.tile = 8'($random(seed));
			e.attr = oam_attr_t'(8'($random(seed)));
			e.idx  = oam_idx_t'(i);
			ents.push_back(e);
		end
	endtask

	// first ten in range in oam order.
	task automatic pick_kept(input line_case_t lc);
		int d;
		kept.delete();
		foreach (ents[i]) begin
			d = int'(lc.line_y) + 16 - int'(ents[i].y);
			if (d >= 0 && d < height_of(lc.tall) && kept.size() < `SPRITE_SLOTS)
				kept.push_back('{x: ents[i].x, tile: ents[i].tile,
					attr: ents[i].attr, idx: ents[i].idx});
		end
	endtask

	task automatic start_line(input line_case_t lc);
		line_start = 1'b1;
		line_y     = lc.line_y;
		tall       = lc.tall;
		step();
		line_start = 1'b0;
	endtask

	// sprites left over from the last line must be gone.
	task automatic check_stale();
		px_active = 1'b1;
		px_valid  = 1'b1;
		foreach (stale_x[i]) begin
			px_x = stale_x[i];
			@(negedge clk);
			expect_true(!hit_valid && px_ready,
				$sformatf("sprite of the previous line still matches x %0d", stale_x[i]));
			expect_true(!oam_ready, "oam_ready high during pixel transfer");
			step();
		end
		px_valid  = 1'b0;
		px_active = 1'b0;
	endtask

	task automatic feed_oam();
		foreach (ents[i]) begin
			oam_valid = 1'b1;
			oam       = ents[i];
			@(negedge clk);
			expect_true(oam_ready, "oam_ready low during oam scan");
			while (!oam_ready)
				@(negedge clk);
			step();
		end
		oam_valid = 1'b0;
		step();
		step(); // last sprite matchable two cycles after acceptance.
	endtask

	task automatic sweep_pixels(input line_case_t lc);
		sprite_hit_t exp;
		px_active = 1'b1;
		for (int k = 0; k < int'(lc.sweep); k++) begin
			px_valid = 1'b1;
			px_x     = lc.x_base + 8'(k);
			foreach (kept[s]) begin
				if (kept[s].x == px_x) begin
					exp = '{spr: kept[s], slot: slot_idx_t'(s)};
					if (lc.hold) begin
						hit_ready = 1'b0;
						repeat (2) begin
							@(negedge clk);
							expect_hit(exp);
							expect_true(!px_ready, "px_ready high while a hit is held");
							step();
						end
					end
					hit_ready = 1'b1;
					@(negedge clk);
					expect_hit(exp);
					expect_true(!px_ready, "px_ready high with a hit pending");
					expect_true(!oam_ready, "oam_ready high during pixel transfer");
					step();
				end
			end
			@(negedge clk);
			expect_true(!hit_valid, $sformatf("extra hit at x %0d, oam index %0d",
				px_x, hit.spr.idx));
			expect_true(px_ready, "px_ready low with no sprite left at this x");
			step();
		end
		px_valid  = 1'b0;
		px_active = 1'b0;
	endtask

	task automatic note_stale(input line_case_t lc);
		int off;
		stale_x.delete();
		foreach (kept[s]) begin
			off = int'(kept[s].x) - int'(lc.x_base);
			if (off < 0 || off >= int'(lc.sweep))
				stale_x.push_back(kept[s].x);
		end
	endtask

	initial begin
		seed       = 32'h741b;
		errors     = 0;
		checks     = 0;
		clk        = 1'b0;
		rst_n      = 1'b0;
		line_start = 1'b0;
		line_y     = '0;
		tall       = 1'b0;
		px_active  = 1'b0;
		oam_valid  = 1'b0;
		oam        = '0;
		px_valid   = 1'b0;
		px_x       = '0;
		hit_ready  = 1'b0;

		cases[0] = '{line_y: 8'd40, tall: 1'b0, n_ent: 6'd40, edge_y: 1'b1,
			x_mask: 8'h0f, x_base: 8'd20, sweep: 5'd12, hold: 1'b0};
		cases[1] = '{line_y: 8'd100, tall: 1'b1, n_ent: 6'd40, edge_y: 1'b1,
			x_mask: 8'h07, x_base: 8'd60, sweep: 5'd8, hold: 1'b1};
		cases[2] = '{line_y: 8'd10, tall: 1'b0, n_ent: 6'd12, edge_y: 1'b0,
			x_mask: 8'h1f, x_base: 8'd0, sweep: 5'd20, hold: 1'b0};
		cases[3] = '{line_y: 8'd143, tall: 1'b1, n_ent: 6'd24, edge_y: 1'b0,
			x_mask: 8'h03, x_base: 8'd160, sweep: 5'd4, hold: 1'b0};
		cases[4] = '{line_y: 8'd0, tall: 1'b1, n_ent: 6'd16, edge_y: 1'b1,
			x_mask: 8'h01, x_base: 8'd8, sweep: 5'd2, hold: 1'b1};
		cases[5] = '{line_y: 8'd200, tall: 1'b0, n_ent: 6'd30, edge_y: 1'b0,
			x_mask: 8'h0f, x_base: 8'd240, sweep: 5'd12, hold: 1'b0};

		cycle_limit = 100;
		foreach (cases[c])
			cycle_limit += 40 + int'(cases[c].sweep) * 11;

		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		expect_true(!hit_valid && !px_ready && !oam_ready, "handshake outputs high after reset");
		step();
		@(negedge clk);
		expect_true(oam_ready, "oam_ready low with px_active low");
		step();

		foreach (cases[c]) begin
			start_line(cases[c]);
			check_stale();
			build_entries(cases[c]);
			pick_kept(cases[c]);
			feed_oam();
			sweep_pixels(cases[c]);
			note_stale(cases[c]);
		end
		start_line(cases[0]);
		check_stale();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== verilog/ppu_sprite_unit.sv ====
`timescale 1ns/1ns
`include "ppu_sprite_cfg.svh"

module ppu_sprite_unit import ppu_oam_pkg::*, ppu_line_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        line_start,
	input  logic [7:0]  line_y,
	input  logic        tall,
	input  logic        px_active,
	input  logic        oam_valid,
	output logic        oam_ready,
	input  oam_entry_t  oam,
	input  logic        px_valid,
	output logic        px_ready,
	input  logic [7:0]  px_x,
	output logic        hit_valid,
	input  logic        hit_ready,
	output sprite_hit_t hit
);

	logic                              slot_we;
	slot_idx_t                         slot_wsel;
	sprite_slot_t                      slot_wdata;
	logic                              retire;
	slot_idx_t                         retire_sel;
	slot_vec_t                         slot_match;
	sprite_slot_t [`SPRITE_SLOTS-1:0] slots;

	// oam scan side.
	oam_line_scanner i_scanner (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_start (line_start),
		.line_y     (line_y),
		.tall       (tall),
		.px_active  (px_active),
		.oam_valid  (oam_valid),
		.oam_ready  (oam_ready),
		.oam        (oam),
		.slot_we    (slot_we),
		.slot_wsel  (slot_wsel),
		.slot_wdata (slot_wdata)
	);

	sprite_x_store i_store (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_start (line_start),
		.slot_we    (slot_we),
		.slot_wsel  (slot_wsel),
		.slot_wdata (slot_wdata),
		.retire     (retire),
		.retire_sel (retire_sel),
		.px_x       (px_x),
		.slot_match (slot_match),
		.slots      (slots)
	);

	// pixel transfer side.
	sprite_match_select i_select (
		.px_valid   (px_valid),
		.px_ready   (px_ready),
		.slot_match (slot_match),
		.slots      (slots),
		.hit_valid  (hit_valid),
		.hit_ready  (hit_ready),
		.hit        (hit),
		.retire     (retire),
		.retire_sel (retire_sel)
	);

endmodule

// ==== verilog/sprite_match_select.sv ====
`timescale 1ns/1ns
`include "ppu_sprite_cfg.svh"

module sprite_match_select import ppu_line_pkg::*; (
	input  logic                              px_valid,
	output logic                              px_ready,
	input  slot_vec_t                         slot_match,
	input  sprite_slot_t [`SPRITE_SLOTS-1:0] slots,
	output logic                              hit_valid,
	input  logic                              hit_ready,
	output sprite_hit_t                       hit,
	output logic                              retire,
	output slot_idx_t                         retire_sel
);

	logic      any_match;
	logic      found;
	slot_idx_t sel;

	// lowest slot wins, which is also lowest oam index.
	always_comb begin
		sel   = '0;
		found = 1'b0;
		for (int i = 0; i < `SPRITE_SLOTS; i++) begin
			if (slot_match[i] && !found) begin
				sel   = slot_idx_t'(i);
				found = 1'b1;
			end
		end
	end

	assign any_match = |slot_match;

	// pixel waits until every sprite at this x is out.
	assign hit_valid = px_valid & any_match;
	assign px_ready  = px_valid & ~any_match;

	assign hit.spr  = slots[sel];
	assign hit.slot = sel;

	assign retire     = hit_valid & hit_ready; // slot freed at next edge.
	assign retire_sel = sel;

endmodule

// ==== verilog/sprite_x_store.sv ====
`timescale 1ns/1ns
`include "ppu_sprite_cfg.svh"

module sprite_x_store import ppu_line_pkg::*; (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              line_start,
	input  logic                              slot_we,
	input  slot_idx_t                         slot_wsel,
	input  sprite_slot_t                      slot_wdata,
	input  logic                              retire,
	input  slot_idx_t                         retire_sel,
	input  logic [7:0]                        px_x,
	output slot_vec_t                         slot_match,
	output sprite_slot_t [`SPRITE_SLOTS-1:0] slots
);

	slot_vec_t                    slot_valid;
	logic [`SPRITE_SLOTS-1:0][7:0] x_diff;

	// valid bits.
	// line_start wipes the whole line, a write beats a retire on the same slot.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid <= '0;
		end else if (line_start) begin
			slot_valid <= '0;
		end else begin
			if (retire)
				slot_valid[retire_sel] <= 1'b0; // sprite taken by fetcher.
			if (slot_we)
				slot_valid[slot_wsel] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (slot_we)
			slots[slot_wsel] <= slot_wdata;
	end

	// per-slot x compare.
	// xor per bit, then a nor across the byte.
	always_comb begin
		for (int i = 0; i < `SPRITE_SLOTS; i++) begin
			x_diff[i]     = slots[i].x ^ px_x;
			slot_match[i] = slot_valid[i] & ~|x_diff[i];
		end
	end

endmodule

// ==== verilog/oam_line_scanner.sv ====
`timescale 1ns/1ns
`include "ppu_sprite_cfg.svh"

module oam_line_scanner import ppu_oam_pkg::*, ppu_line_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         line_start,
	input  logic [7:0]   line_y,
	input  logic         tall,
	input  logic         px_active,
	input  logic         oam_valid,
	output logic         oam_ready,
	input  oam_entry_t   oam,
	output logic         slot_we,
	output slot_idx_t    slot_wsel,
	output sprite_slot_t slot_wdata
);

	logic [7:0] cur_y;
	logic       cur_tall;
	logic       scan_en;
	logic [7:0] eff_y;
	logic       eff_tall;
	logic [8:0] dy;
	logic [8:0] height;
	logic       in_range;
	logic       accept;
	slot_idx_t  alloc_cnt;
	slot_idx_t  alloc_base;
	logic       full;
	logic       take;

	// an entry seen with line_start already belongs to the new line.
	assign eff_y    = line_start ? line_y : cur_y;
	assign eff_tall = line_start ? tall : cur_tall;

	assign oam_ready = scan_en & ~px_active; // oam locked in pixel transfer.
	assign accept    = oam_valid & oam_ready;

	// line position inside the sprite.
	// sprites below the line go negative and wrap well above any height.
	assign dy       = {1'b0, eff_y} + 9'd16 - {1'b0, oam.y};
	assign height   = eff_tall ? 9'(`SPRITE_H_TALL) : 9'(`SPRITE_H_SHORT);
	assign in_range = dy < height;

	assign alloc_base = line_start ? '0 : alloc_cnt;
	assign full       = alloc_base == slot_idx_t'(`SPRITE_SLOTS);
	assign take       = accept & in_range & ~full; // extra hits are dropped.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_en   <= 1'b0;
			alloc_cnt <= '0;
			slot_we   <= 1'b0;
		end else begin
			scan_en   <= 1'b1;
			alloc_cnt <= take ? alloc_base + slot_idx_t'(1) : alloc_base;
			slot_we   <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			cur_y    <= line_y;
			cur_tall <= tall;
		end
		if (take) begin
			slot_wsel  <= alloc_base; // slots fill in oam order.
			slot_wdata <= '{x: oam.x, tile: oam.tile, attr: oam.attr, idx: oam.idx};
		end
	end

endmodule

// ==== verilog/ppu_line_pkg.sv ====
`include "ppu_sprite_cfg.svh"

package ppu_line_pkg;
	import ppu_oam_pkg::*;

	// slot number, wide enough to count a full line.
	typedef logic [$clog2(`SPRITE_SLOTS+1)-1:0] slot_idx_t;

	typedef logic [`SPRITE_SLOTS-1:0] slot_vec_t;

	// what a slot keeps for pixel transfer.
	// y is dropped once the range test has passed.
	typedef struct packed {
		logic [7:0] x;
		logic [7:0] tile;
		oam_attr_t  attr;
		oam_idx_t   idx;
	} sprite_slot_t;

	// record handed to the sprite fetcher on a match.
	typedef struct packed {
		sprite_slot_t spr;
		slot_idx_t    slot;
	} sprite_hit_t;

endpackage

// ==== verilog/ppu_oam_pkg.sv ====
`include "ppu_sprite_cfg.svh"

package ppu_oam_pkg;

	// entry number, also the OAM priority order.
	typedef logic [$clog2(`OAM_ENTRIES)-1:0] oam_idx_t;

	// attribute byte as stored in OAM.
	typedef struct packed {
		logic       bg_prio;  // behind background colors 1-3.
		logic       y_flip;
		logic       x_flip;
		logic       dmg_pal;
		logic       vram_bank;
		logic [2:0] cgb_pal;
	} oam_attr_t;

	// one entry as read out of OAM during the scan.
	typedef struct packed {
		logic [7:0] y;    // screen line plus 16.
		logic [7:0] x;    // screen column plus 8.
		logic [7:0] tile;
		oam_attr_t  attr;
		oam_idx_t   idx;
	} oam_entry_t;

endpackage

// ==== include/ppu_sprite_cfg.svh ====
`ifndef PPU_SPRITE_CFG_SVH
`define PPU_SPRITE_CFG_SVH

// sprites kept per line.
`define SPRITE_SLOTS 10

// entries in object attribute memory.
`define OAM_ENTRIES 40

// sprite heights in lines.
`define SPRITE_H_SHORT 8
`define SPRITE_H_TALL 16

`endif
